// ==== verilog/cgra_params.svh ====
`ifndef CGRA_PARAMS_SVH
`define CGRA_PARAMS_SVH

// datapath and host bus widths
`define DATA_W      32
`define ADDR_W      9
`define MEM_ADDR_W  6
`define MEM_DEPTH   64

// ring size
`define N_STAGE     2
`define N_STAGE_W   1

// run configuration field widths
`define ITER_W      7
`define DELAY_W     3

// host address is {region, stage, index}
`define REGION_W          2
`define REGION_MEM        2'd0
`define REGION_RUN        2'd1
`define REGION_CONF       2'd2
`define REGION_GLOBAL     2'd3
`define GLOBAL_CONF_CLEAR 6'd0

// configuration field indices
`define CONF_IDX_A_START  6'd0
`define CONF_IDX_B_START  6'd1
`define CONF_IDX_A_INCR   6'd2
`define CONF_IDX_B_INCR   6'd3
`define CONF_IDX_ITER     6'd4
`define CONF_IDX_B_DELAY  6'd5
`define CONF_IDX_B_SRC    6'd6
`define CONF_IDX_ALU_OP   6'd7
`define CONF_IDX_ALU_SRC  6'd8
`define CONF_N_FIELD      9

`endif

// ==== verilog/cgra_pkg.sv ====
`default_nettype none

`include "cgra_params.svh"

package cgra_pkg;

   // operand source, seen from the consuming stage
   typedef enum logic [1:0] {
      src_own_mem  = 2'd0,
      src_own_alu  = 2'd1,
      src_prev_mem = 2'd2,
      src_prev_alu = 2'd3
   } src_sel_t;

   typedef enum logic [2:0] {
      alu_add    = 3'd0,
      alu_sub    = 3'd1,
      alu_and    = 3'd2,
      alu_or     = 3'd3,
      alu_xor    = 3'd4,
      alu_max    = 3'd5,
      alu_min    = 3'd6,
      alu_pass_a = 3'd7
   } alu_op_t;

   // one stage's run configuration
   typedef struct packed {
      logic [`MEM_ADDR_W-1:0] a_start;
      logic [`MEM_ADDR_W-1:0] b_start;
      logic [`MEM_ADDR_W-1:0] a_incr;
      logic [`MEM_ADDR_W-1:0] b_incr;
      logic [`ITER_W-1:0]     iter;
      logic [`DELAY_W-1:0]    b_delay;
      src_sel_t               b_src;
      alu_op_t                alu_op;
      src_sel_t               alu_src_a;
      src_sel_t               alu_src_b;
   } stage_conf_t;

   // words a stage hands to its ring neighbour
   typedef struct packed {
      logic [`DATA_W-1:0] mem;
      logic [`DATA_W-1:0] alu;
   } flow_t;

endpackage

`default_nettype wire

// ==== verilog/alu_unit.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cgra_params.svh"

module alu_unit (
   input  logic               clk,
   input  logic               rst,
   input  cgra_pkg::alu_op_t  op,
   input  logic [`DATA_W-1:0] a,
   input  logic [`DATA_W-1:0] b,
   output logic [`DATA_W-1:0] y
);

   logic [`DATA_W-1:0] res;
   logic               a_gt_b;

   // max and min treat the words as two's complement
   assign a_gt_b = $signed(a) > $signed(b);

   always_comb begin
      case (op)
         cgra_pkg::alu_add: res = a + b;
         cgra_pkg::alu_sub: res = a - b;
         cgra_pkg::alu_and: res = a & b;
         cgra_pkg::alu_or:  res = a | b;
         cgra_pkg::alu_xor: res = a ^ b;
         cgra_pkg::alu_max: res = a_gt_b ? a : b;
         cgra_pkg::alu_min: res = a_gt_b ? b : a;
         default:           res = a;
      endcase
   end

   // one cycle from operands to result
   always_ff @(posedge clk) begin
      y <= res;
   end

   // every 3-bit code is an opcode, only an unknown op is illegal
   a_op_legal: assert property (@(posedge clk) disable iff (rst)
      !$isunknown(op));

endmodule

`default_nettype wire

// ==== verilog/data_mem.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cgra_params.svh"

module data_mem (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   run,
   input  cgra_pkg::stage_conf_t  conf,
   input  logic                   host_en,
   input  logic                   host_we,
   input  logic [`MEM_ADDR_W-1:0] host_addr,
   input  logic [`DATA_W-1:0]     host_wdata,
   output logic [`DATA_W-1:0]     host_rdata,
   input  logic [`DATA_W-1:0]     b_data,
   output logic [`DATA_W-1:0]     a_data,
   output logic                   done
);

   logic [`DATA_W-1:0]     mem [`MEM_DEPTH];
   logic [`DATA_W-1:0]     a_q;
   logic                   a_busy;
   logic                   b_busy;
   logic [`ITER_W-1:0]     a_cnt;
   logic [`ITER_W-1:0]     b_cnt;
   logic [`MEM_ADDR_W-1:0] a_off;
   logic [`MEM_ADDR_W-1:0] b_off;
   logic [`DELAY_W-1:0]    b_wait;
   logic [`MEM_ADDR_W-1:0] a_addr;
   logic [`MEM_ADDR_W-1:0] b_addr;
   logic                   has_iter;
   logic                   a_last;
   logic                   b_last;
   logic                   b_we;

   assign has_iter = conf.iter != '0;
   assign a_last   = a_cnt == conf.iter - 1'b1;
   assign b_last   = b_cnt == conf.iter - 1'b1;
   assign b_we     = b_busy && has_iter && b_wait == conf.b_delay;

   // port a belongs to the host while idle
   assign a_addr = a_busy ? conf.a_start + a_off : host_addr;
   assign b_addr = conf.b_start + b_off;

   // read generator, one address per cycle from cycle 0
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         a_busy <= 1'b0;
         a_cnt  <= '0;
         a_off  <= '0;
      end else if (run) begin
         a_busy <= 1'b1;
         a_cnt  <= '0;
         a_off  <= '0;
      end else if (a_busy) begin
         if (!has_iter || a_last) begin
            a_busy <= 1'b0;
         end
         a_cnt <= a_cnt + 1'b1;
         a_off <= a_off + conf.a_incr;
      end
   end

   // write generator, idles b_delay cycles then writes every cycle
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         b_busy <= 1'b0;
         b_wait <= '0;
         b_cnt  <= '0;
         b_off  <= '0;
      end else if (run) begin
         b_busy <= 1'b1;
         b_wait <= '0;
         b_cnt  <= '0;
         b_off  <= '0;
      end else if (b_busy) begin
         if (!has_iter) begin
            b_busy <= 1'b0;
         end else if (b_wait != conf.b_delay) begin
            b_wait <= b_wait + 1'b1;
         end else begin
            if (b_last) begin
               b_busy <= 1'b0;
            end
            b_cnt <= b_cnt + 1'b1;
            b_off <= b_off + conf.b_incr;
         end
      end
   end

   always_ff @(posedge clk) begin
      if (host_en && host_we && !a_busy) begin
         mem[host_addr] <= host_wdata;
      end
      if (b_we) begin
         mem[b_addr] <= b_data;
      end
      if (a_busy || host_en) begin
         a_q <= mem[a_addr];
      end
   end

   assign a_data     = a_q;
   assign host_rdata = a_q;

   // an empty run never drops done
   assign done = !((a_busy || b_busy) && has_iter);

   a_host_idle: assert property (@(posedge clk) disable iff (rst)
      host_en |-> done);

endmodule

`default_nettype wire

// ==== verilog/stage_conf.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cgra_params.svh"

module stage_conf (
   input  logic                   clk,
   input  logic                   rst,
   input  logic                   conf_we,
   input  logic [`MEM_ADDR_W-1:0] conf_idx,
   input  logic [`DATA_W-1:0]     conf_data,
   input  logic                   clear,
   input  logic                   run,
   output cgra_pkg::stage_conf_t  active
);

   // fields written by the host, not yet in use
   cgra_pkg::stage_conf_t staged;

   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         staged <= '0;
      end else if (clear) begin
         staged <= '0;
      end else if (conf_we) begin
         case (conf_idx)
            `CONF_IDX_A_START: staged.a_start <= conf_data[`MEM_ADDR_W-1:0];
            `CONF_IDX_B_START: staged.b_start <= conf_data[`MEM_ADDR_W-1:0];
            `CONF_IDX_A_INCR:  staged.a_incr  <= conf_data[`MEM_ADDR_W-1:0];
            `CONF_IDX_B_INCR:  staged.b_incr  <= conf_data[`MEM_ADDR_W-1:0];
            `CONF_IDX_ITER:    staged.iter    <= conf_data[`ITER_W-1:0];
            `CONF_IDX_B_DELAY: staged.b_delay <= conf_data[`DELAY_W-1:0];
            `CONF_IDX_B_SRC: begin
               staged.b_src <= cgra_pkg::src_sel_t'(conf_data[1:0]);
            end
            `CONF_IDX_ALU_OP: begin
               staged.alu_op <= cgra_pkg::alu_op_t'(conf_data[2:0]);
            end
            // both operand selects share one word, a in the low bits
            `CONF_IDX_ALU_SRC: begin
               staged.alu_src_a <= cgra_pkg::src_sel_t'(conf_data[1:0]);
               staged.alu_src_b <= cgra_pkg::src_sel_t'(conf_data[3:2]);
            end
            default: begin
               staged <= staged;
            end
         endcase
      end
   end

   // active set only changes when a run starts
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         active <= '0;
      end else if (run) begin
         active <= staged;
      end
   end

   a_conf_idx: assert property (@(posedge clk) disable iff (rst)
      conf_we |-> (conf_idx < `CONF_N_FIELD));

endmodule

`default_nettype wire

// ==== verilog/cgra_stage.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cgra_params.svh"

module cgra_stage (
   input  logic               clk,
   input  logic               rst,
   input  logic               valid,
   input  logic               we,
   input  logic [`ADDR_W-1:0] addr,
   input  logic [`DATA_W-1:0] rdata,
   output logic [`DATA_W-1:0] wdata,
   output logic               done,
   input  cgra_pkg::flow_t    flow_in,
   output cgra_pkg::flow_t    flow_out
);

   logic [`REGION_W-1:0]   region;
   logic [`MEM_ADDR_W-1:0] idx;
   logic                   mem_en;
   logic                   conf_we;
   logic                   conf_clear;
   logic                   run;
   cgra_pkg::stage_conf_t  active;
   logic [`DATA_W-1:0]     mem_rdata;
   logic [`DATA_W-1:0]     a_data;
   logic [`DATA_W-1:0]     alu_a;
   logic [`DATA_W-1:0]     alu_b;
   logic [`DATA_W-1:0]     alu_y;
   logic [`DATA_W-1:0]     b_data;

   // pick one of the four ring words
   function automatic logic [`DATA_W-1:0] pick(input cgra_pkg::src_sel_t sel,
                                               input cgra_pkg::flow_t own,
                                               input cgra_pkg::flow_t prev);
      case (sel)
         cgra_pkg::src_own_mem:  pick = own.mem;
         cgra_pkg::src_own_alu:  pick = own.alu;
         cgra_pkg::src_prev_mem: pick = prev.mem;
         default:                pick = prev.alu;
      endcase
   endfunction

   assign region     = addr[`ADDR_W-1 -: `REGION_W];
   assign idx        = addr[`MEM_ADDR_W-1:0];
   assign mem_en     = valid && region == `REGION_MEM;
   assign conf_we    = valid && we && region == `REGION_CONF;
   assign conf_clear = valid && we && region == `REGION_GLOBAL && idx == `GLOBAL_CONF_CLEAR;
   assign run        = valid && we && region == `REGION_RUN;

   assign flow_out.mem = a_data;
   assign flow_out.alu = alu_y;

   assign alu_a  = pick(active.alu_src_a, flow_out, flow_in);
   assign alu_b  = pick(active.alu_src_b, flow_out, flow_in);
   assign b_data = pick(active.b_src, flow_out, flow_in);

   // host read word
   assign wdata = (region == `REGION_MEM) ? mem_rdata : {{(`DATA_W-1){1'b0}}, done};

   stage_conf u_conf (
      .clk       (clk),
      .rst       (rst),
      .conf_we   (conf_we),
      .conf_idx  (idx),
      .conf_data (rdata),
      .clear     (conf_clear),
      .run       (run),
      .active    (active)
   );

   data_mem u_mem (
      .clk        (clk),
      .rst        (rst),
      .run        (run),
      .conf       (active),
      .host_en    (mem_en),
      .host_we    (we),
      .host_addr  (idx),
      .host_wdata (rdata),
      .host_rdata (mem_rdata),
      .b_data     (b_data),
      .a_data     (a_data),
      .done       (done)
   );

   alu_unit u_alu (
      .clk (clk),
      .rst (rst),
      .op  (active.alu_op),
      .a   (alu_a),
      .b   (alu_b),
      .y   (alu_y)
   );

endmodule

`default_nettype wire

// ==== verilog/cgra_top.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cgra_params.svh"

module cgra_top (
   input  logic               clk,
   input  logic               rst,
   input  logic               valid,
   input  logic [`ADDR_W-1:0] addr,
   input  logic               we,
   input  logic [`DATA_W-1:0] rdata,
   output logic               ready,
   output logic [`DATA_W-1:0] wdata
);

   logic [`REGION_W-1:0]  region;
   logic [`N_STAGE_W-1:0] stage_field;
   logic                  run_done;
   logic                  global_clear;
   logic                  mem_read;
   logic                  req;
   logic                  ready_r0;
   logic                  ready_r1;
   logic [`N_STAGE-1:0]   stage_sel;
   logic [`N_STAGE-1:0]   stage_valid;
   logic [`N_STAGE-1:0]   stage_done;
   logic [`DATA_W-1:0]    stage_wdata [`N_STAGE];
   cgra_pkg::flow_t       ring [`N_STAGE];

   assign region       = addr[`ADDR_W-1 -: `REGION_W];
   assign stage_field  = addr[`MEM_ADDR_W +: `N_STAGE_W];
   assign run_done     = region == `REGION_RUN;
   assign global_clear = region == `REGION_GLOBAL && addr[`MEM_ADDR_W-1:0] == `GLOBAL_CONF_CLEAR;
   assign mem_read     = region == `REGION_MEM && !we;

   // one request per access, closed once ready has been given
   assign req = valid && !ready;

   // memory reads wait two more cycles for the registered array output
   always_ff @(posedge clk or posedge rst) begin
      if (rst) begin
         ready_r0 <= 1'b0;
         ready_r1 <= 1'b0;
         ready    <= 1'b0;
      end else begin
         ready_r0 <= req;
         ready_r1 <= ready_r0 && req;
         ready    <= req && (mem_read ? ready_r1 : 1'b1);
      end
   end

   // read data: combined done for the run region, else the addressed stage
   always_comb begin
      wdata = '0;
      if (run_done) begin
         wdata = {{(`DATA_W-1){1'b0}}, &stage_done};
      end else begin
         for (int j = 0; j < `N_STAGE; j++) begin
            if (stage_sel[j]) begin
               wdata = stage_wdata[j];
            end
         end
      end
   end

   // stages in a ring, stage 0 fed by the last one
   for (genvar i = 0; i < `N_STAGE; i++) begin : g_stage
      assign stage_sel[i]   = run_done || global_clear || stage_field == `N_STAGE_W'(i);
      assign stage_valid[i] = req && stage_sel[i];

      cgra_stage u_stage (
         .clk      (clk),
         .rst      (rst),
         .valid    (stage_valid[i]),
         .we       (we),
         .addr     (addr),
         .rdata    (rdata),
         .wdata    (stage_wdata[i]),
         .done     (stage_done[i]),
         .flow_in  (ring[(i + `N_STAGE - 1) % `N_STAGE]),
         .flow_out (ring[i])
      );
   end

   // host must wait for done before touching any memory
   a_mem_idle: assert property (@(posedge clk) disable iff (rst)
      (valid && region == `REGION_MEM) |-> (&stage_done));

endmodule

`default_nettype wire

// ==== bench/cgra_tb.sv ====
`timescale 1ns/10ps
`default_nettype none

`include "cgra_params.svh"

module cgra_tb;

   // host traffic stays near 3500 cycles, limit leaves more than five times that
   localparam int MAX_CYCLES = 20000;

   logic               clk;
   logic               rst;
   logic               valid;
   logic [`ADDR_W-1:0] addr;
   logic               we;
   logic [`DATA_W-1:0] rdata;
   logic               ready;
   logic [`DATA_W-1:0] wdata;

   // expected contents of both stage memories
   logic [`DATA_W-1:0] model_mem [`N_STAGE][`MEM_DEPTH];
   integer             seed = 79656;
   int                 errors = 0;
   int                 checks = 0;
   int                 cycles = 0;
   logic               done_seen = 1'b0;

   cgra_top DUT (
      .clk   (clk),
      .rst   (rst),
      .valid (valid),
      .addr  (addr),
      .we    (we),
      .rdata (rdata),
      .ready (ready),
      .wdata (wdata)
   );

   initial begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   always @(posedge clk) begin
      cycles++;
      if (cycles >= MAX_CYCLES) begin
         $display("timeout after %0d cycles, host access never completed", cycles);
         $display("*** FAILED ***");
         $finish;
      end
   end

   // ready is a one-cycle answer to a held valid
   a_ready_with_valid: assert property (@(posedge clk) disable iff (rst) ready |-> valid)
      else begin
         $display("ready was high while valid was low");
         errors++;
      end

   a_ready_pulse: assert property (@(posedge clk) disable iff (rst) ready |=> !ready)
      else begin
         $display("ready stayed high for more than one cycle");
         errors++;
      end

   // memory is touched only after done was seen
   a_mem_after_done: assert property (@(posedge clk) disable iff (rst)
      (valid && addr[`ADDR_W-1 -: `REGION_W] == `REGION_MEM) |-> done_seen)
      else begin
         $display("memory accessed before done was polled high");
         errors++;
      end

   task automatic check_value(input string name, input logic [`DATA_W-1:0] exp,
                              input logic [`DATA_W-1:0] act);
      checks++;
      assert (exp === act)
      else begin
         $display("FAIL %s expected %h actual %h", name, exp, act);
         errors++;
      end
   endtask

   function automatic logic [`ADDR_W-1:0] host_addr(input logic [`REGION_W-1:0] region,
                                                    input logic [`N_STAGE_W-1:0] stage,
                                                    input logic [`MEM_ADDR_W-1:0] idx);
      host_addr = {region, stage, idx};
   endfunction

   function automatic logic [`DATA_W-1:0] alu_ref(input cgra_pkg::alu_op_t op,
                                                  input logic [`DATA_W-1:0] a,
                                                  input logic [`DATA_W-1:0] b);
      case (op)
         cgra_pkg::alu_add: alu_ref = a + b;
         cgra_pkg::alu_sub: alu_ref = a - b;
         cgra_pkg::alu_and: alu_ref = a & b;
         cgra_pkg::alu_or:  alu_ref = a | b;
         cgra_pkg::alu_xor: alu_ref = a ^ b;
         cgra_pkg::alu_max: alu_ref = ($signed(a) < $signed(b)) ? b : a;
         cgra_pkg::alu_min: alu_ref = ($signed(a) < $signed(b)) ? a : b;
         default:           alu_ref = a;
      endcase
   endfunction

   // one bus access, ready latency checked on the way
   task automatic host_access(input logic [`ADDR_W-1:0] a, input logic w,
                              input logic [`DATA_W-1:0] d, output logic [`DATA_W-1:0] q);
      int n;
      int exp_lat;
      exp_lat = (a[`ADDR_W-1 -: `REGION_W] == `REGION_MEM && !w) ? 3 : 1;
      @(posedge clk);
      valid <= 1'b1;
      addr  <= a;
      we    <= w;
      rdata <= d;
      n = 0;
      do begin
         @(posedge clk);
         n++;
      end while (ready !== 1'b1);
      q = wdata;
      valid <= 1'b0;
      check_value(w ? "write_ready_latency" : "read_ready_latency", exp_lat, n - 1);
   endtask

   task automatic mem_write(input int s, input int i, input logic [`DATA_W-1:0] d);
      logic [`DATA_W-1:0] q;
      host_access(host_addr(`REGION_MEM, `N_STAGE_W'(s), `MEM_ADDR_W'(i)), 1'b1, d, q);
   endtask

   task automatic mem_read(input int s, input int i, output logic [`DATA_W-1:0] q);
      host_access(host_addr(`REGION_MEM, `N_STAGE_W'(s), `MEM_ADDR_W'(i)), 1'b0, '0, q);
   endtask

   task automatic conf_write(input int s, input logic [`MEM_ADDR_W-1:0] idx,
                             input logic [`DATA_W-1:0] d);
      logic [`DATA_W-1:0] q;
      host_access(host_addr(`REGION_CONF, `N_STAGE_W'(s), idx), 1'b1, d, q);
   endtask

   task automatic start_run();
      logic [`DATA_W-1:0] q;
      done_seen = 1'b0;
      host_access(host_addr(`REGION_RUN, '0, '0), 1'b1, '0, q);
   endtask

   task automatic poll_done(output logic q);
      logic [`DATA_W-1:0] word;
      host_access(host_addr(`REGION_RUN, '0, '0), 1'b0, '0, word);
      check_value("done_word_upper", '0, {word[`DATA_W-1:1], 1'b0});
      q = word[0];
      if (q) begin
         done_seen = 1'b1;
      end
   endtask

   task automatic wait_done();
      int   polls;
      logic q;
      polls = 0;
      q = 1'b0;
      while (!q && polls < 64) begin
         poll_done(q);
         polls++;
      end
      if (!q) begin
         $display("done did not rise within %0d polls", polls);
         errors++;
      end
   endtask

   task automatic check_memories(input string name);
      logic [`DATA_W-1:0] q;
      for (int s = 0; s < `N_STAGE; s++) begin
         for (int i = 0; i < `MEM_DEPTH; i++) begin
            mem_read(s, i, q);
            check_value($sformatf("%s_s%0d_w%0d", name, s, i), model_mem[s][i], q);
         end
      end
   endtask

   initial begin
      logic               q;
      logic [`DATA_W-1:0] word;
      rst   = 1'b1;
      valid = 1'b0;
      addr  = '0;
      we    = 1'b0;
      rdata = '0;
      repeat (5) @(posedge clk);
      rst <= 1'b0;
      @(posedge clk);

      // reset state
      check_value("reset_ready", '0, {31'b0, ready});
      poll_done(q);
      check_value("reset_done", 32'd1, {31'b0, q});

      // random fill and readback
      for (int s = 0; s < `N_STAGE; s++) begin
         for (int i = 0; i < `MEM_DEPTH; i++) begin
            word = $random(seed);
            model_mem[s][i] = word;
            mem_write(s, i, word);
         end
      end
      check_memories("mem_readback");

      // stage 0 alu on both memories, stage 1 port b stores at offset 32
      conf_write(0, `CONF_IDX_A_START, 0);
      conf_write(0, `CONF_IDX_A_INCR, 1);
      conf_write(0, `CONF_IDX_ITER, 8);
      conf_write(0, `CONF_IDX_B_START, 0);
      conf_write(0, `CONF_IDX_B_INCR, 1);
      conf_write(0, `CONF_IDX_B_DELAY, 1);
      conf_write(0, `CONF_IDX_B_SRC, 32'(cgra_pkg::src_own_mem));
      conf_write(0, `CONF_IDX_ALU_SRC,
                 32'(cgra_pkg::src_own_mem) | (32'(cgra_pkg::src_prev_mem) << 2));
      conf_write(1, `CONF_IDX_A_START, 0);
      conf_write(1, `CONF_IDX_A_INCR, 1);
      conf_write(1, `CONF_IDX_ITER, 8);
      conf_write(1, `CONF_IDX_B_START, 32);
      conf_write(1, `CONF_IDX_B_INCR, 1);
      conf_write(1, `CONF_IDX_B_DELAY, 2);
      conf_write(1, `CONF_IDX_B_SRC, 32'(cgra_pkg::src_prev_alu));
      for (int op = 0; op < 8; op++) begin
         conf_write(0, `CONF_IDX_ALU_OP, 32'(op));
         start_run();
         poll_done(q);
         check_value("busy_after_run", '0, {31'b0, q});
         wait_done();
         // stage 0 port b writes each word back onto itself
         for (int j = 0; j < 8; j++) begin
            model_mem[1][32 + j] = alu_ref(cgra_pkg::alu_op_t'(op),
                                           model_mem[0][j], model_mem[1][j]);
         end
         for (int j = 0; j < 8; j++) begin
            mem_read(1, 32 + j, word);
            check_value($sformatf("opcode%0d_w%0d", op, j), model_mem[1][32 + j], word);
         end
      end
      check_memories("opcode_all");

      // alu chain into stage 1, strided by 2 with delay 3
      conf_write(0, `CONF_IDX_ALU_OP, 32'(cgra_pkg::alu_add));
      conf_write(1, `CONF_IDX_A_INCR, 2);
      conf_write(1, `CONF_IDX_B_START, 16);
      conf_write(1, `CONF_IDX_B_INCR, 2);
      conf_write(1, `CONF_IDX_B_DELAY, 3);
      conf_write(1, `CONF_IDX_B_SRC, 32'(cgra_pkg::src_own_alu));
      conf_write(1, `CONF_IDX_ALU_OP, 32'(cgra_pkg::alu_pass_a));
      conf_write(1, `CONF_IDX_ALU_SRC,
                 32'(cgra_pkg::src_prev_alu) | (32'(cgra_pkg::src_own_mem) << 2));
      start_run();
      poll_done(q);
      check_value("stride_busy", '0, {31'b0, q});
      wait_done();
      for (int j = 0; j < 8; j++) begin
         model_mem[1][16 + 2 * j] = model_mem[0][j] + model_mem[1][2 * j];
      end
      check_memories("stride");

      // cleared configuration gives an empty run
      host_access(host_addr(`REGION_GLOBAL, '0, `GLOBAL_CONF_CLEAR), 1'b1, '0, word);
      start_run();
      poll_done(q);
      check_value("empty_run_done", 32'd1, {31'b0, q});
      check_memories("after_clear");

      $display("checks %0d, errors %0d", checks, errors);
      if (errors == 0) begin
         $display("*** PASSED ***");
      end else begin
         $display("*** FAILED ***");
      end
      $finish;
   end

endmodule

`default_nettype wire

// ==== cgra.f ====
+incdir+verilog
verilog/cgra_pkg.sv
verilog/alu_unit.sv
verilog/data_mem.sv
verilog/stage_conf.sv
verilog/cgra_stage.sv
verilog/cgra_top.sv
bench/cgra_tb.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the cgra testbench with Verilator

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
      --top-module cgra_tb -f cgra.f -o cgra_sim; then
   echo "verilator build failed"
   exit 1
fi

output=$(./obj_dir/cgra_sim)
status=$?
echo "$output"

if [ "$status" -ne 0 ]; then
   echo "simulation exited with status $status"
   exit 1
fi

if echo "$output" | grep -q '\*\*\* PASSED \*\*\*'; then
   exit 0
fi

echo "pass message not found in simulation output"
exit 1
